// File: Makefile
TOP       ?= tb_decodeTop
SEED      ?= 13238
TRACE     ?= 0
VERILATOR ?= verilator
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

ifeq ($(TRACE),1)
VFLAGS += --trace
endif

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD)"
	@echo "  help   show this list"
	@echo "Variables: TOP SEED TRACE VERILATOR BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f verilog.f
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)

// File: rtl/decodeStage.sv
`default_nettype none

`include "rv_config.svh"

module decodeStage import rv_pkg::*;
(
	input  logic             clk,
	input  logic             nrst,

	// Frontend side
	input  logic [`XLEN-1:0] pc2,
	input  logic [`XLEN-1:0] instr2,
	input  logic             instrValid2,

	// Stall sources
	input  logic             hazardStall,  // From scoreboard
	input  logic             stallMem,
	input  logic             arbEqMem,
	input  logic             memOpDone,

	// Register fields
	output regAddr_t         rs1,
	output regAddr_t         rs2,
	output regAddr_t         rd3,
	output logic [4:0]       shamt,

	// Immediates, sign extended except U
	output logic [`XLEN-1:0] iImm3,
	output logic [`XLEN-1:0] sImm3,
	output logic [`XLEN-1:0] bImm3,
	output logic [`XLEN-1:0] uImm3,
	output logic [`XLEN-1:0] jImm3,

	output logic [`XLEN-1:0] pc3,
	output opcode_e          opcode3,
	output logic             valid3,
	output logic             issue,        // Held instruction moves on

	// Decoded controls
	output logic [1:0]       pcSelect3,
	output logic             we3,
	output logic [1:0]       bSel3,
	output aluFn_e           aluFn3,
	output fnUnit_e          fnUnit3,
	output logic             bNeq3,
	output logic             bType3,
	output logic [2:0]       mulDivOp3,
	output logic             j3,
	output logic             jr3,
	output logic [3:0]       memOp3,
	output logic             lui3,
	output logic             auipc3,
	output logic             illegal3,
	output logic             usesRs1,
	output logic             usesRs2
);

	instrWord_u       instrReg;   // Held word, read through format views
	logic [`XLEN-1:0] pcReg;
	logic             validReg;
	logic             hold;
	logic             decIllegal;

	// Any stall source freezes the stage
	assign hold  = hazardStall | stallMem | (arbEqMem & ~memOpDone);
	assign issue = validReg & ~hold;

	// Stage-3 pipe register
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			instrReg <= '0;
			pcReg    <= `RESET_PC;
			validReg <= 1'b0;
		end
		else if (!hold)
		begin
			instrReg <= instr2;
			pcReg    <= pc2;
			validReg <= instrValid2;
		end
	end

	assign pc3     = pcReg;
	assign valid3  = validReg;
	assign opcode3 = instrReg.r.opcode;

	assign rs1   = instrReg.r.rs1;
	assign rs2   = instrReg.r.rs2;
	assign rd3   = instrReg.r.rd;
	assign shamt = instrReg.r.rs2;   // Same bits as rs2

	// Immediate extraction per format
	assign iImm3 = {{(`XLEN-12){instrReg.i.imm[11]}}, instrReg.i.imm};
	assign sImm3 = {{(`XLEN-12){instrReg.s.immHi[6]}}, instrReg.s.immHi, instrReg.s.immLo};
	assign bImm3 = {{(`XLEN-12){instrReg.b.imm12}}, instrReg.b.imm11,
		instrReg.b.immHi, instrReg.b.immLo, 1'b0};
	assign uImm3 = {instrReg.u.imm, 12'b0};
	assign jImm3 = {{(`XLEN-20){instrReg.j.imm20}}, instrReg.j.immHi,
		instrReg.j.imm11, instrReg.j.immLo, 1'b0};

	// Bubbles never flag illegal
	assign illegal3 = decIllegal & validReg;

	instrDecoder decoder
	(
		.opcode   (instrReg.r.opcode),
		.funct3   (instrReg.r.funct3),
		.funct7   (instrReg.r.funct7),
		.pcSelect (pcSelect3),
		.we       (we3),
		.bSel     (bSel3),
		.aluFn    (aluFn3),
		.fnUnit   (fnUnit3),
		.bNeq     (bNeq3),
		.bType    (bType3),
		.mulDivOp (mulDivOp3),
		.j        (j3),
		.jr       (jr3),
		.memOp    (memOp3),
		.lui      (lui3),
		.auipc    (auipc3),
		.usesRs1  (usesRs1),
		.usesRs2  (usesRs2),
		.illegal  (decIllegal)
	);

endmodule

`default_nettype wire

// File: rtl/decodeTop.sv
`default_nettype none

`include "rv_config.svh"

module decodeTop import rv_pkg::*;
(
	input  logic             clk,
	input  logic             nrst,

	input  logic [`XLEN-1:0] pc2,
	input  logic [`XLEN-1:0] instr2,
	input  logic             instrValid2,

	input  logic             stallMem,
	input  logic             arbEqMem,
	input  logic             memOpDone,

	input  logic             wbEn,
	input  regAddr_t         wbRd,

	output regAddr_t         rs1,
	output regAddr_t         rs2,
	output regAddr_t         rd3,
	output logic [4:0]       shamt,
	output logic [`XLEN-1:0] iImm3,
	output logic [`XLEN-1:0] sImm3,
	output logic [`XLEN-1:0] bImm3,
	output logic [`XLEN-1:0] uImm3,
	output logic [`XLEN-1:0] jImm3,
	output logic [`XLEN-1:0] pc3,
	output opcode_e          opcode3,
	output logic             valid3,
	output logic [1:0]       pcSelect3,
	output logic             we3,
	output logic [1:0]       bSel3,
	output aluFn_e           aluFn3,
	output fnUnit_e          fnUnit3,
	output logic             bNeq3,
	output logic             bType3,
	output logic [2:0]       mulDivOp3,
	output logic             j3,
	output logic             jr3,
	output logic [3:0]       memOp3,
	output logic             lui3,
	output logic             auipc3,
	output logic             illegal3,
	output logic             usesRs1,
	output logic             usesRs2,
	output logic             hazardStall
);

	logic issue;   // Stage to scoreboard, marks rd3 pending

	decodeStage stage
	(
		.clk         (clk),
		.nrst        (nrst),
		.pc2         (pc2),
		.instr2      (instr2),
		.instrValid2 (instrValid2),
		.hazardStall (hazardStall),
		.stallMem    (stallMem),
		.arbEqMem    (arbEqMem),
		.memOpDone   (memOpDone),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd3         (rd3),
		.shamt       (shamt),
		.iImm3       (iImm3),
		.sImm3       (sImm3),
		.bImm3       (bImm3),
		.uImm3       (uImm3),
		.jImm3       (jImm3),
		.pc3         (pc3),
		.opcode3     (opcode3),
		.valid3      (valid3),
		.issue       (issue),
		.pcSelect3   (pcSelect3),
		.we3         (we3),
		.bSel3       (bSel3),
		.aluFn3      (aluFn3),
		.fnUnit3     (fnUnit3),
		.bNeq3       (bNeq3),
		.bType3      (bType3),
		.mulDivOp3   (mulDivOp3),
		.j3          (j3),
		.jr3         (jr3),
		.memOp3      (memOp3),
		.lui3        (lui3),
		.auipc3      (auipc3),
		.illegal3    (illegal3),
		.usesRs1     (usesRs1),
		.usesRs2     (usesRs2)
	);

	// Sits beside the stage, closes the stall loop through registers only
	regScoreboard scoreboard
	(
		.clk         (clk),
		.nrst        (nrst),
		.rs1         (rs1),
		.rs2         (rs2),
		.usesRs1     (usesRs1),
		.usesRs2     (usesRs2),
		.valid3      (valid3),
		.rd3         (rd3),
		.we3         (we3),
		.issue       (issue),
		.wbEn        (wbEn),
		.wbRd        (wbRd),
		.hazardStall (hazardStall)
	);

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
`default_nettype none

module instrDecoder import rv_pkg::*;
(
	input  opcode_e    opcode,
	input  logic [2:0] funct3,
	input  logic [6:0] funct7,

	output logic [1:0] pcSelect,  // Next PC source, resolved in execute
	output logic       we,        // Regfile write enable
	output logic [1:0] bSel,      // Operand B source
	output aluFn_e     aluFn,
	output fnUnit_e    fnUnit,
	output logic       bNeq,      // Invert compare result
	output logic       bType,     // Relational compare, else equality
	output logic [2:0] mulDivOp,
	output logic       j,
	output logic       jr,
	output logic [3:0] memOp,     // {store, unsigned, size}
	output logic       lui,
	output logic       auipc,
	output logic       usesRs1,
	output logic       usesRs2,
	output logic       illegal
);

	// PC select encodings
	localparam logic [1:0] PcSeq    = 2'b00;
	localparam logic [1:0] PcBranch = 2'b01;
	localparam logic [1:0] PcJal    = 2'b10;
	localparam logic [1:0] PcJalr   = 2'b11;

	// Operand B encodings
	localparam logic [1:0] BRs2  = 2'b00;
	localparam logic [1:0] BImmI = 2'b01;
	localparam logic [1:0] BImmS = 2'b10;
	localparam logic [1:0] BImmU = 2'b11;

	always_comb
	begin
		// Quiet defaults, also what an illegal word leaves behind
		pcSelect = PcSeq;
		we       = 1'b0;
		bSel     = BRs2;
		aluFn    = ALU_ADD;
		fnUnit   = FU_ALU;
		bNeq     = 1'b0;
		bType    = 1'b0;
		mulDivOp = 3'b000;
		j        = 1'b0;
		jr       = 1'b0;
		memOp    = 4'b0000;
		lui      = 1'b0;
		auipc    = 1'b0;
		usesRs1  = 1'b0;
		usesRs2  = 1'b0;
		illegal  = 1'b0;

		case (opcode)
			OPC_LOAD:
			begin
				// LB LH LW LBU LHU only
				if (funct3 == 3'b011 || funct3[2:1] == 2'b11)
					illegal = 1'b1;
				else
				begin
					we      = 1'b1;
					bSel    = BImmI;        // Address = rs1 + I imm
					fnUnit  = FU_MEM;
					memOp   = {1'b0, funct3};
					usesRs1 = 1'b1;
				end
			end
			OPC_STORE:
			begin
				if (funct3[2] || funct3[1:0] == 2'b11)
					illegal = 1'b1;
				else
				begin
					bSel    = BImmS;
					fnUnit  = FU_MEM;
					memOp   = {1'b1, funct3};
					usesRs1 = 1'b1;
					usesRs2 = 1'b1;         // Store data
				end
			end
			OPC_BRANCH:
			begin
				if (funct3[2:1] == 2'b01)
					illegal = 1'b1;         // 010 and 011 unused
				else
				begin
					pcSelect = PcBranch;
					fnUnit   = FU_BRANCH;
					bNeq     = funct3[0];   // BNE BGE BGEU
					bType    = funct3[2];
					usesRs1  = 1'b1;
					usesRs2  = 1'b1;
					// Equality via subtract, ordering via set-less-than
					if (!funct3[2])
						aluFn = ALU_SUB;
					else if (funct3[1])
						aluFn = ALU_SLTU;
					else
						aluFn = ALU_SLT;
				end
			end
			OPC_JAL:
			begin
				we       = 1'b1;            // Link register
				pcSelect = PcJal;
				fnUnit   = FU_JUMP;
				j        = 1'b1;
			end
			OPC_JALR:
			begin
				if (funct3 != 3'b000)
					illegal = 1'b1;
				else
				begin
					we       = 1'b1;
					pcSelect = PcJalr;
					bSel     = BImmI;
					fnUnit   = FU_JUMP;
					jr       = 1'b1;
					usesRs1  = 1'b1;
				end
			end
			OPC_OP_IMM:
			begin
				// Shift immediates constrain funct7
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					illegal = 1'b1;
				else if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)
					illegal = 1'b1;
				else
				begin
					we      = 1'b1;
					bSel    = BImmI;
					usesRs1 = 1'b1;
					// Only SRAI carries the funct7 bit, ADDI has no SUB form
					aluFn   = aluFn_e'({funct3 == 3'b101 && funct7[5], funct3});
				end
			end
			OPC_OP:
			begin
				if (funct7 == 7'b0000001)
				begin
					we       = 1'b1;
					fnUnit   = FU_MULDIV;
					mulDivOp = funct3;      // MUL..REMU in funct3 order
					usesRs1  = 1'b1;
					usesRs2  = 1'b1;
				end
				else if (funct7 == 7'b0000000 ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
				begin
					we      = 1'b1;
					aluFn   = aluFn_e'({funct7[5], funct3}); // SUB and SRA
					usesRs1 = 1'b1;
					usesRs2 = 1'b1;
				end
				else
					illegal = 1'b1;
			end
			OPC_LUI:
			begin
				we   = 1'b1;
				bSel = BImmU;               // Execute zeroes operand A
				lui  = 1'b1;
			end
			OPC_AUIPC:
			begin
				we    = 1'b1;
				bSel  = BImmU;              // PC + U imm
				auipc = 1'b1;
			end
			default:
				illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/regScoreboard.sv
`default_nettype none

`include "rv_config.svh"

module regScoreboard import rv_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,

	// Sources of the held instruction
	input  regAddr_t rs1,
	input  regAddr_t rs2,
	input  logic     usesRs1,
	input  logic     usesRs2,
	input  logic     valid3,

	// Destination, marked on issue
	input  regAddr_t rd3,
	input  logic     we3,
	input  logic     issue,

	// Writeback report
	input  logic     wbEn,
	input  regAddr_t wbRd,

	output logic     hazardStall
);

	localparam int NumRegs = 1 << `REG_ADDR_W;

	logic [NumRegs-1:0] pending;   // One bit per register, x0 stays clear
	logic               setEn;

	assign setEn = issue & we3 & (rd3 != '0);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			pending <= '0;
		else
		begin
			if (wbEn)
				pending[wbRd] <= 1'b0;
			// Later assignment, set beats a same-cycle clear
			if (setEn)
				pending[rd3] <= 1'b1;
		end
	end

	// Same-cycle view of the pending bits
	assign hazardStall = valid3 &
		((usesRs1 & pending[rs1]) | (usesRs2 & pending[rs2]));

endmodule

`default_nettype wire

// File: rtl/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Core widths for the RV32IM decode stage

// Data and PC width
`define XLEN 32

// Architectural register index width, 32 registers
`define REG_ADDR_W 5

// Value of pc3 out of reset
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/rv_pkg.sv
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

	// Register index as carried between the stage and the scoreboard
	typedef logic [`REG_ADDR_W-1:0] regAddr_t;

	// RV32 major opcodes, base integer and M extension only
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111
	} opcode_e;

	// Execute unit that takes the instruction
	typedef enum logic [2:0] {
		FU_ALU    = 3'd0,
		FU_BRANCH = 3'd1,
		FU_MEM    = 3'd2,
		FU_MULDIV = 3'd3,
		FU_JUMP   = 3'd4
	} fnUnit_e;

	// Encoded as {funct7[5], funct3} so OP and OP_IMM map directly
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_SRA  = 4'b1101
	} aluFn_e;

	// Instruction formats, fields listed from bit 31 down
	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		regAddr_t   rd;
		opcode_e    opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm;     // imm[11:0]
		regAddr_t    rs1;
		logic [2:0]  funct3;
		regAddr_t    rd;
		opcode_e     opcode;
	} iFmt_t;

	typedef struct packed {
		logic [6:0] immHi;    // imm[11:5]
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;    // imm[4:0]
		opcode_e    opcode;
	} sFmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] immHi;    // imm[10:5]
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [3:0] immLo;    // imm[4:1]
		logic       imm11;
		opcode_e    opcode;
	} bFmt_t;

	typedef struct packed {
		logic [19:0] imm;     // imm[31:12]
		regAddr_t    rd;
		opcode_e     opcode;
	} uFmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] immLo;    // imm[10:1]
		logic       imm11;
		logic [7:0] immHi;    // imm[19:12]
		regAddr_t   rd;
		opcode_e    opcode;
	} jFmt_t;

	// One instruction word, each format a view of the same bits
	typedef union packed {
		rFmt_t r;
		iFmt_t i;
		sFmt_t s;
		bFmt_t b;
		uFmt_t u;
		jFmt_t j;
	} instrWord_u;

endpackage

`default_nettype wire

// File: tb/decode_properties.sv
`default_nettype none

`include "rv_config.svh"

module decode_properties
(
	input logic             clk,
	input logic             nrst,
	input logic             hold,
	input logic             issue,
	input logic             validReg,
	input logic [`XLEN-1:0] pcReg,
	input logic [`XLEN-1:0] instrReg   // Union seen as a flat word
);

	// A held edge leaves the pipe register untouched
	property holdKeepsContent;
		@(posedge clk) disable iff (!nrst)
		hold |=> ($stable(instrReg) && $stable(pcReg) && $stable(validReg));
	endproperty

	property issueNeedsValid;
		@(posedge clk) disable iff (!nrst)
		issue |-> validReg;
	endproperty

	holdKeepsContentA: assert property (holdKeepsContent)
		else $error("Pipe register changed while the stage was held");
	issueNeedsValidA: assert property (issueNeedsValid)
		else $error("issue high with an empty stage");

endmodule

`default_nettype wire

// File: tb/tb_decodeTop.sv
`default_nettype none

`include "rv_config.svh"

module tb_decodeTop import rv_pkg::*;
();

	localparam int Period      = 20;
	localparam int ResetCycles = 10;

	// Control bits {valid, stallMem, arbEqMem, memOpDone, wbEn}
	localparam logic [4:0] Go       = 5'b10000;
	localparam logic [4:0] MemStall = 5'b11000;
	localparam logic [4:0] ArbWait  = 5'b10100;
	localparam logic [4:0] ArbDone  = 5'b10110;
	localparam logic [4:0] WbDone   = 5'b10001;

	// Which immediate output an entry checks
	localparam logic [2:0] ImmNone  = 3'd0;
	localparam logic [2:0] ImmI     = 3'd1;
	localparam logic [2:0] ImmS     = 3'd2;
	localparam logic [2:0] ImmB     = 3'd3;
	localparam logic [2:0] ImmU     = 3'd4;
	localparam logic [2:0] ImmJ     = 3'd5;
	localparam logic [2:0] ImmShamt = 3'd6;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [4:0]  ctl;
		logic [4:0]  wbRd;
		logic [2:0]  sel;
		logic [31:0] imm;
		logic [4:0]  rd;
		logic [3:0]  alu;
		logic        we;
		logic [2:0]  fu;
		logic        ill;
		logic        stall;
		logic [31:0] pc3;   // Expected pc3, previous one under hold
	} stimEntry_t;

	stimEntry_t stim[$];
	stimEntry_t cur;     // Entry being assembled

	logic             clk;
	logic             nrst;
	logic [`XLEN-1:0] pc2;
	logic [`XLEN-1:0] instr2;
	logic             instrValid2;
	logic             stallMem;
	logic             arbEqMem;
	logic             memOpDone;
	logic             wbEn;
	regAddr_t         wbRd;

	regAddr_t         rs1;
	regAddr_t         rs2;
	regAddr_t         rd3;
	logic [4:0]       shamt;
	logic [`XLEN-1:0] iImm3;
	logic [`XLEN-1:0] sImm3;
	logic [`XLEN-1:0] bImm3;
	logic [`XLEN-1:0] uImm3;
	logic [`XLEN-1:0] jImm3;
	logic [`XLEN-1:0] pc3;
	opcode_e          opcode3;
	logic             valid3;
	logic [1:0]       pcSelect3;
	logic             we3;
	logic [1:0]       bSel3;
	aluFn_e           aluFn3;
	fnUnit_e          fnUnit3;
	logic             bNeq3;
	logic             bType3;
	logic [2:0]       mulDivOp3;
	logic             j3;
	logic             jr3;
	logic [3:0]       memOp3;
	logic             lui3;
	logic             auipc3;
	logic             illegal3;
	logic             usesRs1;
	logic             usesRs2;
	logic             hazardStall;

	decodeTop UUT
	(
		.clk         (clk),
		.nrst        (nrst),
		.pc2         (pc2),
		.instr2      (instr2),
		.instrValid2 (instrValid2),
		.stallMem    (stallMem),
		.arbEqMem    (arbEqMem),
		.memOpDone   (memOpDone),
		.wbEn        (wbEn),
		.wbRd        (wbRd),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd3         (rd3),
		.shamt       (shamt),
		.iImm3       (iImm3),
		.sImm3       (sImm3),
		.bImm3       (bImm3),
		.uImm3       (uImm3),
		.jImm3       (jImm3),
		.pc3         (pc3),
		.opcode3     (opcode3),
		.valid3      (valid3),
		.pcSelect3   (pcSelect3),
		.we3         (we3),
		.bSel3       (bSel3),
		.aluFn3      (aluFn3),
		.fnUnit3     (fnUnit3),
		.bNeq3       (bNeq3),
		.bType3      (bType3),
		.mulDivOp3   (mulDivOp3),
		.j3          (j3),
		.jr3         (jr3),
		.memOp3      (memOp3),
		.lui3        (lui3),
		.auipc3      (auipc3),
		.illegal3    (illegal3),
		.usesRs1     (usesRs1),
		.usesRs2     (usesRs2),
		.hazardStall (hazardStall)
	);

	bind decodeStage decode_properties props
	(
		.clk         (clk),
		.nrst        (nrst),
		.hold        (hold),
		.issue       (issue),
		.validReg    (validReg),
		.pcReg       (pcReg),
		.instrReg    (instrReg)
	);

	// RV32 encoders, immediates scattered per format
	function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [4:0] rs2r,
		input logic [4:0] rs1r, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2r, rs1r, f3, rd, opc};
	endfunction

	function automatic logic [31:0] iWord(input logic [11:0] imm, input logic [4:0] rs1r,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1r, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sWord(input logic [11:0] imm, input logic [4:0] rs2r,
		input logic [4:0] rs1r, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2r, rs1r, f3, imm[4:0], opc};
	endfunction

	function automatic logic [31:0] bWord(input logic [12:0] imm, input logic [4:0] rs2r,
		input logic [4:0] rs1r, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[12], imm[10:5], rs2r, rs1r, f3, imm[4:1], imm[11], opc};
	endfunction

	function automatic logic [31:0] uWord(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] jWord(input logic [20:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
	endfunction

	// Expected {redirect, immB, j, jr, lui, auipc, usesRs1, usesRs2, bNeq, bType, memOp}
	function automatic logic [13:0] controlsFor(input logic [31:0] w);
		logic [13:0] c;
		logic [2:0]  f3;
		c  = '0;
		f3 = w[14:12];
		case (w[6:0])
			OPC_LOAD:   c = {2'b01, 4'b0000, 2'b10, 2'b00, 1'b0, f3};
			OPC_STORE:  c = {2'b01, 4'b0000, 2'b11, 2'b00, 1'b1, f3};
			OPC_BRANCH: c = {2'b10, 4'b0000, 2'b11, f3[0], f3[2], 4'b0000};
			OPC_JAL:    c = {2'b10, 4'b1000, 2'b00, 2'b00, 4'b0000};
			OPC_JALR:   c = {2'b11, 4'b0100, 2'b10, 2'b00, 4'b0000};
			OPC_OP_IMM: c = {2'b01, 4'b0000, 2'b10, 2'b00, 4'b0000};
			OPC_OP:     c = {2'b00, 4'b0000, 2'b11, 2'b00, 4'b0000};
			OPC_LUI:    c = {2'b01, 4'b0010, 2'b00, 2'b00, 4'b0000};
			OPC_AUIPC:  c = {2'b01, 4'b0001, 2'b00, 2'b00, 4'b0000};
			default:    c = '0;   // Illegal, nothing enabled
		endcase
		return c;
	endfunction

	task automatic present(input logic [31:0] instr, input logic [31:0] pc,
		input logic [4:0] ctl, input logic [4:0] wbReg);
		cur.instr = instr;
		cur.pc    = pc;
		cur.ctl   = ctl;
		cur.wbRd  = wbReg;
	endtask

	// Completes cur with the outputs seen one edge later, then queues it
	task automatic expectOut(input logic [2:0] sel, input logic [31:0] imm,
		input logic [4:0] rd, input logic [3:0] alu, input logic we, input logic [2:0] fu,
		input logic ill, input logic stall, input logic [31:0] pc);
		cur.sel   = sel;
		cur.imm   = imm;
		cur.rd    = rd;
		cur.alu   = alu;
		cur.we    = we;
		cur.fu    = fu;
		cur.ill   = ill;
		cur.stall = stall;
		cur.pc3   = pc;
		stim.push_back(cur);
	endtask

	// ADDI x0 with random immediate, pc and writeback address
	task automatic randomNop();
		logic [11:0] imm;
		logic [31:0] pc;
		imm = 12'($urandom);
		pc  = $urandom & 32'hFFFF_FFFC;
		present(iWord(imm, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), pc, Go, 5'($urandom));
		expectOut(ImmI, {{20{imm[11]}}, imm}, 5'd0, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, pc);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s: got 32'h%h, expected 32'h%h",
				$time, name, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic buildStim();
		// Immediate formats, sources on x0 so nothing stalls
		present(iWord(12'hF85, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 32'h100, Go, 5'd0);
		expectOut(ImmI, 32'hFFFF_FF85, 5'd1, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h100);
		present(iWord(12'h7FF, 5'd0, 3'b010, 5'd2, OPC_LOAD), 32'h104, Go, 5'd0);
		expectOut(ImmI, 32'h0000_07FF, 5'd2, ALU_ADD, 1'b1, FU_MEM, 1'b0, 1'b0, 32'h104);
		present(sWord(12'hFFC, 5'd0, 5'd0, 3'b010, OPC_STORE), 32'h108, Go, 5'd0);
		expectOut(ImmS, 32'hFFFF_FFFC, 5'd28, ALU_ADD, 1'b0, FU_MEM, 1'b0, 1'b0, 32'h108);
		present(bWord(13'h1F38, 5'd0, 5'd0, 3'b001, OPC_BRANCH), 32'h10C, Go, 5'd0);
		expectOut(ImmB, 32'hFFFF_FF38, 5'd25, ALU_SUB, 1'b0, FU_BRANCH, 1'b0, 1'b0, 32'h10C);
		present(bWord(13'h0800, 5'd0, 5'd0, 3'b110, OPC_BRANCH), 32'h110, Go, 5'd0);
		expectOut(ImmB, 32'h0000_0800, 5'd1, ALU_SLTU, 1'b0, FU_BRANCH, 1'b0, 1'b0, 32'h110);
		present(uWord(20'hABCDE, 5'd3, OPC_LUI), 32'h114, Go, 5'd0);
		expectOut(ImmU, 32'hABCD_E000, 5'd3, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h114);
		present(uWord(20'h80001, 5'd4, OPC_AUIPC), 32'h118, Go, 5'd0);
		expectOut(ImmU, 32'h8000_1000, 5'd4, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h118);
		present(jWord(21'h1ABCD6, 5'd1, OPC_JAL), 32'h11C, Go, 5'd0);
		expectOut(ImmJ, 32'hFFFA_BCD6, 5'd1, ALU_ADD, 1'b1, FU_JUMP, 1'b0, 1'b0, 32'h11C);
		present(iWord(12'h123, 5'd0, 3'b000, 5'd6, OPC_JALR), 32'h120, Go, 5'd0);
		expectOut(ImmI, 32'h0000_0123, 5'd6, ALU_ADD, 1'b1, FU_JUMP, 1'b0, 1'b0, 32'h120);
		present(iWord({7'b0100000, 5'd13}, 5'd0, 3'b101, 5'd7, OPC_OP_IMM), 32'h124, Go, 5'd0);
		expectOut(ImmShamt, 32'd13, 5'd7, ALU_SRA, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h124);
		present(iWord({7'b0000000, 5'd31}, 5'd0, 3'b001, 5'd8, OPC_OP_IMM), 32'h128, Go, 5'd0);
		expectOut(ImmShamt, 32'd31, 5'd8, ALU_SLL, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h128);
		// Register ops, funct7 picks the variant
		present(rWord(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd9, OPC_OP), 32'h12C, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd9, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h12C);
		present(rWord(7'b0100000, 5'd0, 5'd0, 3'b000, 5'd10, OPC_OP), 32'h130, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd10, ALU_SUB, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h130);
		present(rWord(7'b0000000, 5'd0, 5'd0, 3'b101, 5'd11, OPC_OP), 32'h134, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd11, ALU_SRL, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h134);
		present(rWord(7'b0100000, 5'd0, 5'd0, 3'b101, 5'd12, OPC_OP), 32'h138, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd12, ALU_SRA, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h138);
		present(rWord(7'b0000001, 5'd0, 5'd0, 3'b011, 5'd13, OPC_OP), 32'h13C, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd13, ALU_ADD, 1'b1, FU_MULDIV, 1'b0, 1'b0, 32'h13C);
		// Unknown opcode, rs1 = x9 is pending but unused
		present(rWord(7'h55, 5'd3, 5'd9, 3'b010, 5'd20, 7'h7F), 32'h140, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd20, ALU_ADD, 1'b0, FU_ALU, 1'b1, 1'b0, 32'h140);
		// Memory stall, then arbiter wait
		present(iWord(12'h055, 5'd0, 3'b000, 5'd16, OPC_OP_IMM), 32'h144, Go, 5'd0);
		expectOut(ImmI, 32'h0000_0055, 5'd16, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h144);
		present(uWord(20'h12345, 5'd17, OPC_LUI), 32'h148, MemStall, 5'd0);
		expectOut(ImmI, 32'h0000_0055, 5'd16, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h144);
		present(uWord(20'h12345, 5'd17, OPC_LUI), 32'h148, Go, 5'd0);
		expectOut(ImmU, 32'h1234_5000, 5'd17, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h148);
		present(uWord(20'h00FFF, 5'd18, OPC_AUIPC), 32'h14C, ArbWait, 5'd0);
		expectOut(ImmU, 32'h1234_5000, 5'd17, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h148);
		present(uWord(20'h00FFF, 5'd18, OPC_AUIPC), 32'h14C, ArbDone, 5'd0);
		expectOut(ImmU, 32'h00FF_F000, 5'd18, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h14C);
		// RAW on x5, released by writeback
		present(iWord(12'h001, 5'd0, 3'b000, 5'd5, OPC_OP_IMM), 32'h150, Go, 5'd0);
		expectOut(ImmI, 32'h0000_0001, 5'd5, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h150);
		present(rWord(7'b0000000, 5'd0, 5'd5, 3'b000, 5'd14, OPC_OP), 32'h154, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd14, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b1, 32'h154);
		present(iWord(12'h007, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 32'h158, WbDone, 5'd5);
		expectOut(ImmNone, 32'd0, 5'd14, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h154);
		present(iWord(12'h007, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 32'h158, Go, 5'd0);
		expectOut(ImmI, 32'h0000_0007, 5'd0, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h158);
		// Reads x0 right after a write to x0
		present(rWord(7'b0000000, 5'd0, 5'd0, 3'b000, 5'd15, OPC_OP), 32'h15C, Go, 5'd0);
		expectOut(ImmNone, 32'd0, 5'd15, ALU_ADD, 1'b1, FU_ALU, 1'b0, 1'b0, 32'h15C);
		repeat (6)
			randomNop();
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#(Period / 2) clk = ~clk;
	end

	initial
	begin
		#1;   // Table is built at time zero
		#((ResetCycles + stim.size() * 20) * Period);
		$display("Some tests failed");
		$fatal(1, "Run timed out before the stimulus table finished");
	end

	initial
	begin
		stimEntry_t  e;
		logic [31:0] held;   // Word the stage should be holding
		void'($urandom(32'h33b6));
		buildStim();
		// Valid word offered during reset must not be taken
		nrst        = 1'b0;
		pc2         = 32'h0000_0FF0;
		instr2      = iWord(12'h0AA, 5'd0, 3'b000, 5'd1, OPC_OP_IMM);
		instrValid2 = 1'b1;
		stallMem    = 1'b0;
		arbEqMem    = 1'b0;
		memOpDone   = 1'b0;
		wbEn        = 1'b0;
		wbRd        = '0;
		held        = '0;
		repeat (ResetCycles)
		begin
			@(posedge clk);
			#1;
			checkValue("valid3", 32'(valid3), 32'd0);
			checkValue("we3", 32'(we3), 32'd0);
			checkValue("hazardStall", 32'(hazardStall), 32'd0);
			checkValue("pc3", pc3, `RESET_PC);
		end
		#1;
		nrst = 1'b1;
		for (int k = 0; k < stim.size(); k++)
		begin
			e      = stim[k];
			instr2 = e.instr;
			pc2    = e.pc;
			wbRd   = e.wbRd;
			{instrValid2, stallMem, arbEqMem, memOpDone, wbEn} = e.ctl;
			if (e.pc3 == e.pc)   // Taken this edge, else the old word stays
				held = e.instr;
			@(posedge clk);
			#1;   // Outputs settled after the sampling edge
			checkValue("valid3", 32'(valid3), 32'd1);
			checkValue("pc3", pc3, e.pc3);
			checkValue("rd3", 32'(rd3), 32'(e.rd));
			checkValue("aluFn3", 32'(aluFn3), 32'(e.alu));
			checkValue("we3", 32'(we3), 32'(e.we));
			checkValue("fnUnit3", 32'(fnUnit3), 32'(e.fu));
			checkValue("illegal3", 32'(illegal3), 32'(e.ill));
			checkValue("hazardStall", 32'(hazardStall), 32'(e.stall));
			checkValue("opcode3", 32'(opcode3), 32'(held[6:0]));
			checkValue("rs1", 32'(rs1), 32'(held[19:15]));
			checkValue("rs2", 32'(rs2), 32'(held[24:20]));
			checkValue("controls", 32'({pcSelect3 != 2'b00, bSel3 != 2'b00, j3, jr3, lui3,
				auipc3, usesRs1, usesRs2, bNeq3, bType3, memOp3}), 32'(controlsFor(held)));
			case (e.sel)
				ImmI:     checkValue("iImm3", iImm3, e.imm);
				ImmS:     checkValue("sImm3", sImm3, e.imm);
				ImmB:     checkValue("bImm3", bImm3, e.imm);
				ImmU:     checkValue("uImm3", uImm3, e.imm);
				ImmJ:     checkValue("jImm3", jImm3, e.imm);
				ImmShamt: checkValue("shamt", 32'(shamt), e.imm);
				default:  ;
			endcase
			if (e.fu == FU_MULDIV)
				checkValue("mulDivOp3", 32'(mulDivOp3), 32'(e.instr[14:12]));
			if (e.ill)   // Nothing may be enabled on an illegal word
				checkValue("enables", 32'({pcSelect3, j3, jr3, lui3, auipc3, memOp3,
					usesRs1, usesRs2}), 32'd0);
			#1;
		end
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/instrDecoder.sv
rtl/decodeStage.sv
rtl/regScoreboard.sv
rtl/decodeTop.sv
tb/decode_properties.sv
tb/tb_decodeTop.sv
